// File: source/matmul_cfg.svh
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

////////////////////
// Matrix geometry
////////////////////

// Square matrices, rows and columns
`define MM_N 4

// Unsigned element, sums wrap at this width
`define MM_ELEM_W 16

// One full matrix row per memory word
`define MM_WORD_W (`MM_N * `MM_ELEM_W)

// Enough bits to index MM_N rows
`define MM_ADDR_W 2

`endif

// File: source/matmul_pkg.sv
package matmul_pkg;

  `include "matmul_cfg.svh"

  // One matrix element
  typedef logic [`MM_ELEM_W-1:0] elem_t;

  // Row or inner index
  typedef logic [`MM_ADDR_W-1:0] row_addr_t;

  ////////////////////
  // Row word views
  ////////////////////

  // Memories and host port see one flat word,
  // the MAC lanes pick elements out of it.
  // Element 0 sits in the low bits
  typedef union packed {
    logic [`MM_WORD_W-1:0] flat;
    elem_t [`MM_N-1:0]     elems;
  } row_word_u;

endpackage

// File: source/row_ram.sv
`timescale 1ns/1ps

`include "matmul_cfg.svh"

module row_ram (
  input  logic                  clk_mem,
  input  logic [`MM_ADDR_W-1:0] addr,
  input  logic                  we,
  input  logic [`MM_WORD_W-1:0] wr_data,
  output logic [`MM_WORD_W-1:0] rd_data
);

  // One word per matrix row
  logic [`MM_WORD_W-1:0] mem [`MM_N];

  // Write port
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wr_data;
    end
  end

  // Registered read, data follows addr by one cycle
  always_ff @(posedge clk_mem) begin
    rd_data <= mem[addr];
  end

endmodule

// File: source/step_counter.sv
`timescale 1ns/1ps

`include "matmul_cfg.svh"

module step_counter
  import matmul_pkg::*;
(
  input  logic      clk_mem,
  input  logic      reset,
  input  logic      clear,
  input  logic      advance,
  output row_addr_t row_idx,
  output row_addr_t k_idx,
  output logic      last_k,
  output logic      last_row
);

  // Final positions of the walk
  assign last_k   = (k_idx == row_addr_t'(`MM_N - 1));
  assign last_row = (row_idx == row_addr_t'(`MM_N - 1));

  ////////////////////
  // Nested index pair
  ////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset || clear) begin
      row_idx <= '0;
      k_idx   <= '0;
    end else if (advance) begin
      if (last_k) begin
        k_idx <= '0;
        // Inner index wrapped, move to next C row
        if (last_row) begin
          row_idx <= '0;
        end else begin
          row_idx <= row_idx + 1'b1;
        end
      end else begin
        k_idx <= k_idx + 1'b1;
      end
    end
  end

endmodule

// File: source/matmul_fsm.sv
`timescale 1ns/1ps

module matmul_fsm (
  input  logic clk_mem,
  input  logic reset,
  input  logic start_req,
  output logic start_ack,
  output logic busy,
  output logic cnt_clear,
  output logic cnt_advance,
  input  logic last_k,
  input  logic last_row,
  output logic acc_clear,
  output logic acc_en,
  output logic c_we
);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_FETCH = 3'd1;
  localparam logic [2:0] ST_ACC   = 3'd2;
  localparam logic [2:0] ST_WRITE = 3'd3;
  localparam logic [2:0] ST_DONE  = 3'd4;

  logic [2:0] state;
  logic [2:0] state_nxt;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start_req) begin
          state_nxt = ST_FETCH;
        end
      end
      ST_FETCH: state_nxt = ST_ACC;
      ST_ACC:   state_nxt = last_k ? ST_WRITE : ST_FETCH;
      ST_WRITE: state_nxt = last_row ? ST_DONE : ST_FETCH;
      // Hold ack until the host lets go of start_req
      ST_DONE: begin
        if (!start_req) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign busy      = (state == ST_FETCH) || (state == ST_ACC) || (state == ST_WRITE);
  assign start_ack = (state == ST_DONE);
  assign acc_en    = (state == ST_ACC);
  assign c_we      = (state == ST_WRITE);
  assign cnt_clear = (state == ST_IDLE) && start_req;

  // Fresh accumulators for every C row
  assign acc_clear = cnt_clear || (state == ST_WRITE);

  // Row index must stay put until the write cycle is over
  assign cnt_advance = ((state == ST_ACC) && !last_k) || (state == ST_WRITE);

endmodule

// File: source/row_mac.sv
`timescale 1ns/1ps

`include "matmul_cfg.svh"

module row_mac
  import matmul_pkg::*;
(
  input  logic      clk_mem,
  input  logic      reset,
  input  logic      acc_clear,
  input  logic      acc_en,
  input  row_addr_t k_idx,
  input  row_word_u a_row,
  input  row_word_u b_row,
  output row_word_u acc_row
);

  row_addr_t k_q;
  elem_t     a_elem;

  // Memory read lags its address by a cycle, so does the element select
  always_ff @(posedge clk_mem) begin
    k_q <= k_idx;
  end

  // A element shared by all lanes this step
  assign a_elem = a_row.elems[k_q];

  ////////////////////
  // MAC lanes
  ////////////////////

  // Lane j holds C[row][j]; products and sums wrap at 16 bits
  always_ff @(posedge clk_mem) begin
    if (reset || acc_clear) begin
      acc_row <= '0;
    end else if (acc_en) begin
      for (int j = 0; j < `MM_N; j++) begin
        acc_row.elems[j] <= acc_row.elems[j] + a_elem * b_row.elems[j];
      end
    end
  end

endmodule

// File: source/matmul_top.sv
`timescale 1ns/1ps

module matmul_top
  import matmul_pkg::*;
(
  input  logic      clk_mem,
  input  logic      reset,
  input  logic      load_en,
  input  logic      load_sel,
  input  row_addr_t load_addr,
  input  row_word_u load_data,
  input  logic      start_req,
  output logic      start_ack,
  input  logic      rd_en,
  input  row_addr_t rd_addr,
  output row_word_u rd_data
);

  logic      busy;
  logic      cnt_clear;
  logic      cnt_advance;
  logic      last_k;
  logic      last_row;
  logic      acc_clear;
  logic      acc_en;
  logic      c_we;
  logic      load_wr;
  row_addr_t row_idx;
  row_addr_t k_idx;
  row_addr_t rd_addr_q;
  row_addr_t a_addr;
  row_addr_t b_addr;
  row_addr_t c_addr;
  row_word_u a_q;
  row_word_u b_q;
  row_word_u acc_row;

  ////////////////////
  // Control
  ////////////////////

  matmul_fsm u_fsm (
    .clk_mem     (clk_mem),
    .reset       (reset),
    .start_req   (start_req),
    .start_ack   (start_ack),
    .busy        (busy),
    .cnt_clear   (cnt_clear),
    .cnt_advance (cnt_advance),
    .last_k      (last_k),
    .last_row    (last_row),
    .acc_clear   (acc_clear),
    .acc_en      (acc_en),
    .c_we        (c_we)
  );

  step_counter u_counter (
    .clk_mem  (clk_mem),
    .reset    (reset),
    .clear    (cnt_clear),
    .advance  (cnt_advance),
    .row_idx  (row_idx),
    .k_idx    (k_idx),
    .last_k   (last_k),
    .last_row (last_row)
  );

  row_mac u_mac (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .k_idx     (k_idx),
    .a_row     (a_q),
    .b_row     (b_q),
    .acc_row   (acc_row)
  );

  ////////////////////
  // Address steering
  ////////////////////

  // Host loads only between runs, handshake fully idle
  assign load_wr = load_en && !busy && !start_req && !start_ack;

  // Last host read address, keeps rd_data steady between reads
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  assign a_addr = busy ? row_idx : load_addr;
  assign b_addr = busy ? k_idx : load_addr;
  assign c_addr = busy ? row_idx : (rd_en ? rd_addr : rd_addr_q);

  ////////////////////
  // Row memories
  ////////////////////

  row_ram u_mem_a (
    .clk_mem (clk_mem),
    .addr    (a_addr),
    .we      (load_wr && !load_sel),
    .wr_data (load_data.flat),
    .rd_data (a_q)
  );

  row_ram u_mem_b (
    .clk_mem (clk_mem),
    .addr    (b_addr),
    .we      (load_wr && load_sel),
    .wr_data (load_data.flat),
    .rd_data (b_q)
  );

  // C takes a finished row during the write cycle
  row_ram u_mem_c (
    .clk_mem (clk_mem),
    .addr    (c_addr),
    .we      (c_we),
    .wr_data (acc_row.flat),
    .rd_data (rd_data)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_mem,
  output logic reset
);

  // 100 ns period
  localparam time HALF_PERIOD = 50;

  initial begin
    clk_mem = 1'b0;
    forever #HALF_PERIOD clk_mem = ~clk_mem;
  end

  // Synchronous reset held for five rising edges
  initial begin
    reset <= 1'b1;
    repeat (5) @(posedge clk_mem);
    reset <= 1'b0;
  end

endmodule

// File: verification/matmul_tb.sv
`timescale 1ns/1ps

`include "matmul_cfg.svh"

module matmul_tb
  import matmul_pkg::*;
();

  localparam int ACK_TIMEOUT   = 200;
  localparam int RESET_TIMEOUT = 20;

  logic      clk_mem;
  logic      reset;
  logic      load_en;
  logic      load_sel;
  row_addr_t load_addr;
  row_word_u load_data;
  logic      start_req;
  logic      start_ack;
  logic      rd_en;
  row_addr_t rd_addr;
  row_word_u rd_data;

  // Host copies of the operands
  elem_t a_m [`MM_N][`MM_N];
  elem_t b_m [`MM_N][`MM_N];

  logic [31:0] rng_state;
  int          errors;
  int          checks;

  tb_clock_gen u_clock_gen (
    .clk_mem (clk_mem),
    .reset   (reset)
  );

  matmul_top u_matmul_top (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .load_addr (load_addr),
    .load_data (load_data),
    .start_req (start_req),
    .start_ack (start_ack),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic elem_t rand_elem();
    rng_state = lcg_step(rng_state);
    return rng_state[31:16];
  endfunction

  // C[i][j] as a plain sum of products that wraps at 16 bits
  function automatic elem_t ref_elem(input int i, input int j);
    elem_t sum;
    sum = '0;
    for (int k = 0; k < `MM_N; k++) begin
      sum = sum + a_m[i][k] * b_m[k][j];
    end
    return sum;
  endfunction

  task automatic compare_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Host port tasks
  ////////////////////

  task automatic load_row(input logic sel, input int r, input row_word_u w);
    @(posedge clk_mem);
    load_en   <= 1'b1;
    load_sel  <= sel;
    load_addr <= row_addr_t'(r);
    load_data <= w;
    @(posedge clk_mem);
    load_en   <= 1'b0;
  endtask

  // Loads A for sel 0 and B for sel 1
  task automatic load_matrix(input logic sel);
    row_word_u w;
    for (int r = 0; r < `MM_N; r++) begin
      for (int j = 0; j < `MM_N; j++) begin
        w.elems[j] = sel ? b_m[r][j] : a_m[r][j];
      end
      load_row(sel, r, w);
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
      @(posedge clk_mem);
      cycles++;
    end
    if (reset !== 1'b0) begin
      errors++;
      $display("Reset never went low within %0d cycles", RESET_TIMEOUT);
    end
  endtask

  // Sampled on the falling edge between DUT updates
  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk_mem);
    while (start_ack !== level && cycles < ACK_TIMEOUT) begin
      @(negedge clk_mem);
      cycles++;
    end
    if (start_ack !== level) begin
      errors++;
      $display("Timed out at %0t waiting for start_ack to become %0b", $time, level);
    end
  endtask

  task automatic raise_start();
    @(posedge clk_mem);
    start_req <= 1'b1;
    wait_ack(1'b1);
  endtask

  task automatic drop_start();
    @(posedge clk_mem);
    start_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  // Read every C row and hold it against the reference
  task automatic check_c(input string tag);
    for (int r = 0; r < `MM_N; r++) begin
      @(posedge clk_mem);
      rd_en   <= 1'b1;
      rd_addr <= row_addr_t'(r);
      @(posedge clk_mem);
      rd_en   <= 1'b0;
      // A new address without rd_en leaves the row on rd_data
      rd_addr <= row_addr_t'(r + 1);
      repeat (2) begin
        @(negedge clk_mem);
        for (int j = 0; j < `MM_N; j++) begin
          compare_val($sformatf("%s rd_data[%0d].elems[%0d]", tag, r, j),
                      rd_data.elems[j], ref_elem(r, j));
        end
      end
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    row_word_u junk;
    rng_state = 32'h9ecc_e0dd;
    errors    = 0;
    checks    = 0;
    load_en   <= 1'b0;
    load_sel  <= 1'b0;
    load_addr <= '0;
    load_data <= '0;
    start_req <= 1'b0;
    rd_en     <= 1'b0;
    rd_addr   <= '0;
    wait_reset();

    @(negedge clk_mem);
    compare_val("start_ack after reset", {15'b0, start_ack}, 16'h0000);

    // Identity A makes C come back as B
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        a_m[i][j] = (i == j) ? 16'h0001 : 16'h0000;
        b_m[i][j] = rand_elem();
      end
    end
    load_matrix(1'b0);
    load_matrix(1'b1);
    raise_start();
    drop_start();
    check_c("identity");

    // Random A against the same B
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        a_m[i][j] = rand_elem();
      end
    end
    load_matrix(1'b0);
    raise_start();
    drop_start();
    check_c("random");

    // Host holds start_req after the ack
    raise_start();
    repeat (5) begin
      @(negedge clk_mem);
      compare_val("start_ack while held", {15'b0, start_ack}, 16'h0001);
    end
    junk.flat = '1;
    load_row(1'b0, 0, junk);
    check_c("held");
    drop_start();
    // Rerun with the same operands shows whether the blocked load got in
    raise_start();
    drop_start();
    check_c("rerun");

    // Large A values against the kept B force wraparound
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        a_m[i][j] = 16'hffff - (rand_elem() & 16'h000f);
      end
    end
    load_matrix(1'b0);
    raise_start();
    drop_start();
    check_c("wrap");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+source
source/matmul_pkg.sv
source/row_ram.sv
source/step_counter.sv
source/matmul_fsm.sv
source/row_mac.sv
source/matmul_top.sv
verification/tb_clock_gen.sv
verification/matmul_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the matrix multiplier testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module matmul_tb -f build.f -o sim_matmul

./obj_dir/sim_matmul | tee "$LOG"

if grep -q "All tests passed!" "$LOG"; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
